// File: verilog/rtc_pkg.sv
package rtc_pkg;

  // 7-bit bus address of the clock chip
  localparam logic [6:0] RTC_ADDR = 7'h6F;

  // seconds, minutes, hours, weekday, date, month, year
  localparam int RTC_NREGS = 7;

  // poll interval is 2**RTC_POLL_BITS clock cycles
  // kept short so a simulation sees several polls
  localparam int RTC_POLL_BITS = 14;

  // system clocks per quarter of one SCL period
  localparam int I2C_QUARTER = 4;

  // seconds register bit 7 is the oscillator start flag, not time
  localparam logic [7:0] RTC_ST_MASK = 8'h7F;

endpackage

// File: verilog/lcd_pkg.sv
package lcd_pkg;

  // panel geometry, one row of 16 digit cells
  localparam int LCD_W = 64;
  localparam int LCD_H = 8;

  // RGB565 pixels
  localparam int COLOR_BITS = 16;
  localparam logic [COLOR_BITS-1:0] COLOR_FG = 16'hFFFF;
  localparam logic [COLOR_BITS-1:0] COLOR_BG = 16'h0000;

  // memory write, opens the pixel data of a frame
  localparam logic [7:0] CMD_RAMWR = 8'h2C;

  // shown word is century byte on top of the 56-bit datetime
  localparam int DISP_BITS = 64;
  localparam logic [7:0] CENTURY = 8'h20;

  // 3x5 hex font, row 0 in bits 14:12, leftmost column is the row msb
  localparam logic [14:0] HEX_FONT [16] = '{
    15'b111_101_101_101_111,
    15'b010_110_010_010_111,
    15'b111_001_111_100_111,
    15'b111_001_111_001_111,
    15'b101_101_111_001_001,
    15'b111_100_111_001_111,
    15'b111_100_111_101_111,
    15'b111_001_001_001_001,
    15'b111_101_111_101_111,
    15'b111_101_111_001_111,
    15'b010_101_111_101_101,
    15'b110_101_110_101_110,
    15'b111_100_100_100_111,
    15'b110_101_101_101_110,
    15'b111_100_111_100_111,
    15'b111_100_111_100_100
  };

endpackage

// File: verilog/rtc_reader.sv
module rtc_reader import rtc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  inout  wire                    sda,
  inout  wire                    scl,
  output logic [RTC_NREGS*8-1:0] datetime,
  output logic                   tick
);

  typedef enum logic [1:0] {ST_IDLE, ST_START, ST_BYTE, ST_STOP} state_t;

  state_t                         state;
  logic [RTC_POLL_BITS-1:0]       poll_cnt;
  logic [$clog2(I2C_QUARTER)-1:0] qcnt;
  logic [1:0]                     qph;
  logic [3:0]                     bit_idx;
  logic [$clog2(RTC_NREGS)-1:0]   byte_idx;
  logic [1:0]                     seg;
  logic                           rd;
  logic                           ok;
  logic                           scl_low;
  logic                           sda_low;
  logic [7:0]                     sh;
  logic [RTC_NREGS*8-1:0]         shadow;

  // open drain, pull-ups live on the board
  assign scl = scl_low ? 1'b0 : 1'bz;
  assign sda = sda_low ? 1'b0 : 1'bz;

  // seg: 0 address+write, 1 register pointer, 2 address+read, 3 data bytes
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      poll_cnt <= '0;
      qcnt     <= '0;
      qph      <= '0;
      bit_idx  <= '0;
      byte_idx <= '0;
      seg      <= '0;
      rd       <= 1'b0;
      ok       <= 1'b0;
      scl_low  <= 1'b0;
      sda_low  <= 1'b0;
      datetime <= '0;
      tick     <= 1'b0;
    end
    else
    begin
      tick     <= 1'b0;
      poll_cnt <= poll_cnt + 1'b1;
      if (state == ST_IDLE)
      begin
        qcnt <= '0;
        qph  <= '0;
        // new poll on counter wrap
        if (&poll_cnt)
        begin
          state <= ST_START;
          seg   <= 2'd0;
          ok    <= 1'b0;
        end
      end
      else if (int'(qcnt) != I2C_QUARTER - 1)
        qcnt <= qcnt + 1'b1;
      else
      begin
        qcnt <= '0;
        qph  <= qph + 1'b1;
        case (state)
          // also serves as repeated start with scl low
          ST_START:
          begin
            case (qph)
              2'd0: sda_low <= 1'b0;
              2'd1: scl_low <= 1'b0;
              2'd2: sda_low <= 1'b1;
              default:
              begin
                scl_low <= 1'b1;
                sh      <= {RTC_ADDR, seg == 2'd2};
                bit_idx <= '0;
                rd      <= 1'b0;
                state   <= ST_BYTE;
              end
            endcase
          end
          ST_BYTE:
          begin
            case (qph)
              // set up sda while scl is low
              2'd0:
              begin
                if (bit_idx == 4'd8)
                  sda_low <= rd && (byte_idx != ($bits(byte_idx))'(RTC_NREGS - 1));
                else
                  sda_low <= !rd && !sh[7];
              end
              2'd1: scl_low <= 1'b0;
              2'd2:
              begin
                if (rd && bit_idx != 4'd8)
                  sh <= {sh[6:0], sda};
              end
              default:
              begin
                scl_low <= 1'b1;
                if (bit_idx != 4'd8)
                begin
                  bit_idx <= bit_idx + 1'b1;
                  if (!rd)
                    sh <= {sh[6:0], 1'b0};
                end
                else
                begin
                  bit_idx <= '0;
                  // slave still holds its ack, scl is high until this edge
                  if (!rd && sda)
                    state <= ST_STOP;
                  else
                  begin
                    case (seg)
                      2'd0:
                      begin
                        seg <= 2'd1;
                        sh  <= 8'h00;
                      end
                      2'd1:
                      begin
                        seg   <= 2'd2;
                        state <= ST_START;
                      end
                      2'd2:
                      begin
                        seg      <= 2'd3;
                        rd       <= 1'b1;
                        byte_idx <= '0;
                      end
                      default:
                      begin
                        shadow[{byte_idx, 3'b000} +: 8] <= sh;
                        if (byte_idx == ($bits(byte_idx))'(RTC_NREGS - 1))
                        begin
                          ok    <= 1'b1;
                          state <= ST_STOP;
                        end
                        else
                          byte_idx <= byte_idx + 1'b1;
                      end
                    endcase
                  end
                end
              end
            endcase
          end
          default:
          begin
            case (qph)
              2'd0: sda_low <= 1'b1;
              2'd1: scl_low <= 1'b0;
              2'd2: sda_low <= 1'b0;
              default:
              begin
                state <= ST_IDLE;
                // publish only a complete read
                if (ok)
                begin
                  datetime <= {shadow[RTC_NREGS*8-1:8], shadow[7:0] & RTC_ST_MASK};
                  tick     <= 1'b1;
                end
              end
            endcase
          end
        endcase
      end
    end
  end

  // one update per poll
  assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick);

  // bus clock left free between polls
  assert property (@(posedge clk) disable iff (!rst_n) (state == ST_IDLE) |-> !scl_low);

endmodule

// File: verilog/hex_glyph.sv
module hex_glyph import lcd_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [DISP_BITS-9:0]     datetime,
  input  logic                     frame_start,
  input  logic [$clog2(LCD_W)-1:0] x,
  input  logic [$clog2(LCD_H)-1:0] y,
  output logic [COLOR_BITS-1:0]    color
);

  logic [DISP_BITS-1:0] disp;
  logic [3:0]           digit;
  logic [14:0]          glyph;
  logic [2:0]           row_bits;
  logic [1:0]           col;
  logic                 pix_on;

  // display word held still for a whole frame
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      disp <= {CENTURY, {(DISP_BITS-8){1'b0}}};
    else if (frame_start)
      disp <= {CENTURY, datetime};
  end

  always_comb
  begin
    // nibble 15 - x/4, most significant digit at the left
    digit    = disp[{~x[5:2], 2'b00} +: 4];
    glyph    = HEX_FONT[digit];
    col      = x[1:0];
    row_bits = 3'b000;
    pix_on   = 1'b0;
    // glyph occupies columns 0..2 and cell rows 1..5
    if (col != 2'd3 && y >= 3'd1 && y <= 3'd5)
    begin
      row_bits = glyph[3 * (5 - int'(y)) +: 3];
      pix_on   = row_bits[2 - int'(col)];
    end
  end

  // one cycle from x,y to color
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      color <= COLOR_BG;
    else
      color <= pix_on ? COLOR_FG : COLOR_BG;
  end

  // a new display word is taken while the scan sits on the top left pixel
  assert property (@(posedge clk) disable iff (!rst_n)
    frame_start |-> (x == '0 && y == '0));

endmodule

// File: verilog/lcd_stream.sv
module lcd_stream import lcd_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [COLOR_BITS-1:0]    color,
  output logic [$clog2(LCD_W)-1:0] x,
  output logic [$clog2(LCD_H)-1:0] y,
  output logic                     next_pixel,
  output logic                     frame_start,
  output logic                     spi_clk,
  output logic                     spi_mosi,
  output logic                     spi_dc,
  output logic                     spi_resn
);

  typedef enum logic [1:0] {ST_RESET, ST_GAP, ST_CMD, ST_PIX} state_t;

  state_t                state;
  // cycle count in reset and gap, bit index while shifting
  logic [3:0]            cnt;
  logic [COLOR_BITS-1:0] sh;
  logic                  word_end;
  logic                  gap_end;

  // last bit of the byte or pixel finishes on this falling edge
  assign word_end = spi_clk && ((state == ST_CMD) ? (cnt == 4'd7) : (cnt == 4'd15));
  // x,y wrapped to 0,0 after the last pixel was loaded
  assign next_pixel = word_end && (state == ST_CMD || x != '0 || y != '0);
  assign gap_end = (state == ST_GAP) && (cnt == 4'd15);
  assign spi_mosi = sh[COLOR_BITS-1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state       <= ST_RESET;
      cnt         <= '0;
      spi_clk     <= 1'b0;
      spi_dc      <= 1'b1;
      spi_resn    <= 1'b0;
      frame_start <= 1'b0;
    end
    else
    begin
      frame_start <= 1'b0;
      case (state)
        ST_RESET:
        begin
          cnt <= cnt + 1'b1;
          if (cnt == 4'd15)
          begin
            spi_resn <= 1'b1;
            state    <= ST_GAP;
          end
        end
        ST_GAP:
        begin
          cnt <= cnt + 1'b1;
          if (gap_end)
          begin
            state       <= ST_CMD;
            spi_dc      <= 1'b0;
            frame_start <= 1'b1;
          end
        end
        default:
        begin
          // spi_clk at half the system clock
          spi_clk <= ~spi_clk;
          if (spi_clk)
          begin
            cnt <= cnt + 1'b1;
            if (word_end)
            begin
              cnt <= '0;
              if (state == ST_CMD)
              begin
                state  <= ST_PIX;
                spi_dc <= 1'b1;
              end
              else if (!next_pixel)
                state <= ST_GAP;
            end
          end
        end
      endcase
    end
  end

  // data moves on the falling edge of spi_clk
  always_ff @(posedge clk)
  begin
    if (gap_end)
      sh <= {CMD_RAMWR, {(COLOR_BITS-8){1'b0}}};
    else if (next_pixel)
      sh <= color;
    else if (spi_clk)
      sh <= {sh[COLOR_BITS-2:0], 1'b0};
  end

  // pixel scan, x fastest
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      x <= '0;
      y <= '0;
    end
    else if (next_pixel)
    begin
      if (int'(x) == LCD_W - 1)
      begin
        x <= '0;
        y <= (int'(y) == LCD_H - 1) ? '0 : y + 1'b1;
      end
      else
        x <= x + 1'b1;
    end
  end

  // command byte is exactly eight spi clocks long
  assert property (@(posedge clk) disable iff (!rst_n)
    $fell(spi_dc) |=> (!spi_dc) [*15] ##1 spi_dc);

endmodule

// File: verilog/rtc_lcd_top.sv
module rtc_lcd_top import rtc_pkg::*, lcd_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  inout  wire                    sda,
  inout  wire                    scl,
  output logic [RTC_NREGS*8-1:0] datetime,
  output logic                   tick,
  output logic                   spi_clk,
  output logic                   spi_mosi,
  output logic                   spi_dc,
  output logic                   spi_resn
);

  logic [$clog2(LCD_W)-1:0] x;
  logic [$clog2(LCD_H)-1:0] y;
  logic                     frame_start;
  logic [COLOR_BITS-1:0]    color;

  // clock chip poller
  rtc_reader u_reader (
    .clk      (clk),
    .rst_n    (rst_n),
    .sda      (sda),
    .scl      (scl),
    .datetime (datetime),
    .tick     (tick)
  );

  // digit row renderer, picks up datetime at each frame start
  hex_glyph u_glyph (
    .clk         (clk),
    .rst_n       (rst_n),
    .datetime    (datetime),
    .frame_start (frame_start),
    .x           (x),
    .y           (y),
    .color       (color)
  );

  // panel scan and SPI shifter
  lcd_stream u_stream (
    .clk         (clk),
    .rst_n       (rst_n),
    .color       (color),
    .x           (x),
    .y           (y),
    .next_pixel  (),
    .frame_start (frame_start),
    .spi_clk     (spi_clk),
    .spi_mosi    (spi_mosi),
    .spi_dc      (spi_dc),
    .spi_resn    (spi_resn)
  );

endmodule

// File: bench/rtc_i2c_model.sv
module rtc_i2c_model import rtc_pkg::*;
(
  inout  wire                    sda,
  inout  wire                    scl,
  input  logic [RTC_NREGS*8-1:0] regs,
  input  logic                   force_nack
);

  timeunit 1ns;
  timeprecision 100ps;

  logic       sda_drv;
  logic       scl_q;
  logic       sda_q;
  // addressed since the last start
  logic       active;
  logic       expect_ptr;
  logic       reading;
  logic       rd_pending;
  logic       master_ack;
  logic [7:0] sh;
  logic [7:0] ptr;
  int         bitcnt;

  // open drain, the bench supplies the pull-ups
  assign sda = sda_drv ? 1'b0 : 1'bz;

  // register file view, seconds in the low byte
  function automatic logic [7:0] reg_at(input logic [7:0] p);
    if (int'(p) < RTC_NREGS)
      return regs[int'(p)*8 +: 8];
    else
      return 8'hFF;
  endfunction

  initial
  begin
    sda_drv    = 1'b0;
    scl_q      = 1'b1;
    sda_q      = 1'b1;
    active     = 1'b0;
    expect_ptr = 1'b0;
    reading    = 1'b0;
    rd_pending = 1'b0;
    master_ack = 1'b0;
    sh         = 8'h00;
    ptr        = 8'h00;
    bitcnt     = 0;
  end

  always @(scl or sda)
  begin
    if (scl_q === 1'b1 && scl === 1'b1 && sda_q !== sda)
    begin
      // sda moving while scl high is a start or a stop
      if (sda === 1'b0)
      begin
        active     = 1'b1;
        expect_ptr = 1'b0;
        reading    = 1'b0;
        rd_pending = 1'b0;
        master_ack = 1'b0;
        bitcnt     = 0;
      end
      else
      begin
        active  = 1'b0;
        reading = 1'b0;
        sda_drv = 1'b0;
      end
    end
    else if (active && scl_q !== 1'b1 && scl === 1'b1)
    begin
      // rising scl, take a data bit or the master's ack
      if (bitcnt < 8)
      begin
        if (!reading)
          sh = {sh[6:0], sda};
        bitcnt++;
      end
      else
      begin
        master_ack = (sda === 1'b0);
        bitcnt     = 0;
      end
    end
    else if (active && scl_q === 1'b1 && scl === 1'b0)
    begin
      if (bitcnt == 8)
      begin
        // ack slot follows
        if (reading)
          sda_drv = 1'b0;
        else if (force_nack)
        begin
          sda_drv = 1'b0;
          active  = 1'b0;
        end
        else if (!expect_ptr)
        begin
          if (sh[7:1] == RTC_ADDR)
          begin
            sda_drv    = 1'b1;
            rd_pending = sh[0];
            expect_ptr = !sh[0];
          end
          else
          begin
            sda_drv = 1'b0;
            active  = 1'b0;
          end
        end
        else
        begin
          ptr        = sh;
          expect_ptr = 1'b0;
          sda_drv    = 1'b1;
        end
      end
      else if (bitcnt == 0)
      begin
        // ack slot over, send the next register or let go
        if (rd_pending || (reading && master_ack))
        begin
          reading    = 1'b1;
          rd_pending = 1'b0;
          sh         = reg_at(ptr);
          ptr        = ptr + 8'd1;
          sda_drv    = !sh[7];
        end
        else
        begin
          reading = 1'b0;
          sda_drv = 1'b0;
        end
      end
      else if (reading)
      begin
        sh      = {sh[6:0], 1'b0};
        sda_drv = !sh[7];
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

// File: bench/tb_rtc_lcd.sv
module tb_rtc_lcd import rtc_pkg::*, lcd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NPIX = LCD_W * LCD_H;
  localparam int POLL = 2 ** RTC_POLL_BITS;

  logic                   clk;
  logic                   rst_n;
  wire                    sda;
  wire                    scl;
  logic [RTC_NREGS*8-1:0] datetime;
  logic                   tick;
  logic                   spi_clk;
  logic                   spi_mosi;
  logic                   spi_dc;
  logic                   spi_resn;
  logic [RTC_NREGS*8-1:0] regs;
  logic                   force_nack;
  logic [RTC_NREGS*8-1:0] cur_regs;
  logic [RTC_NREGS*8-1:0] prev_dt;

  // SPI frame decoder state
  logic                   dc_q;
  logic                   sclk_q;
  logic [15:0]            dsh;
  int                     dbits;
  int                     frames;
  logic [RTC_NREGS*8-1:0] frame_dt;
  logic [7:0]             cmd_q[$];
  logic [15:0]            pix_q[$];

  pullup (sda);
  pullup (scl);

  rtc_lcd_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .sda      (sda),
    .scl      (scl),
    .datetime (datetime),
    .tick     (tick),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .spi_dc   (spi_dc),
    .spi_resn (spi_resn)
  );

  rtc_i2c_model rtc (
    .sda        (sda),
    .scl        (scl),
    .regs       (regs),
    .force_nack (force_nack)
  );

  always #2 clk = ~clk;

  // expected colour of pixel px,py for display word disp
  function automatic logic [15:0] expected_pixel(input logic [63:0] disp, input int px,
                                                 input int py);
    logic [3:0]  digit;
    logic [14:0] font;
    int          col;
    int          r;
    digit = disp[(15 - px / 4) * 4 +: 4];
    font  = HEX_FONT[digit];
    col   = px % 4;
    r     = py - 1;
    // blank column 3 and rows above and below the glyph
    if (col == 3 || r < 0 || r > 4)
      return COLOR_BG;
    // glyph row r lives in bits 14-3r down to 12-3r, column 0 first
    if (font[14 - 3 * r - col])
      return COLOR_FG;
    return COLOR_BG;
  endfunction

  // seven valid-looking BCD registers, oscillator bit set in seconds
  function automatic logic [RTC_NREGS*8-1:0] random_regs();
    logic [RTC_NREGS*8-1:0] r;
    for (int i = 0; i < RTC_NREGS; i++)
      r[i*8 +: 8] = {4'($urandom_range(0, 5)), 4'($urandom_range(0, 9))};
    r[7] = 1'b1;
    return r;
  endfunction

  // what datetime should hold after reading r
  function automatic logic [RTC_NREGS*8-1:0] packed_time(input logic [RTC_NREGS*8-1:0] r);
    return {r[RTC_NREGS*8-1:8], 1'b0, r[6:0]};
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
    else
      stop_with_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_reset_state();
    check_value("tick", 64'(tick), 64'(1'b0));
    check_value("spi_resn", 64'(spi_resn), 64'(1'b0));
    check_value("spi_clk", 64'(spi_clk), 64'(1'b0));
    check_value("spi_dc", 64'(spi_dc), 64'(1'b1));
    check_value("scl", 64'(scl), 64'(1'b1));
    check_value("sda", 64'(sda), 64'(1'b1));
    check_value("datetime", 64'(datetime), 64'h0);
  endtask

  task automatic wait_tick(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (tick !== 1'b1)
    begin
      if (n >= limit)
        stop_with_failure("the RTC reader gave no tick within the cycle limit");
      else
      begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_frame(input int limit);
    int n;
    int f0;
    n  = 0;
    f0 = frames;
    while (frames == f0)
    begin
      if (n >= limit)
        stop_with_failure("no LCD frame started within the cycle limit");
      else
      begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_pixels(input int limit);
    int n;
    n = 0;
    while (pix_q.size() < NPIX)
    begin
      if (n >= limit)
        stop_with_failure("the LCD frame did not deliver all pixels in time");
      else
      begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  // compare one decoded frame against the reference
  task automatic check_frame();
    logic [15:0] pix[$];
    logic [63:0] disp;
    pix  = pix_q;
    disp = {CENTURY, frame_dt};
    check_value("command count", 64'(cmd_q.size()), 64'd1);
    check_value("command byte", 64'(cmd_q[0]), 64'(CMD_RAMWR));
    check_value("pixel count", 64'(pix.size()), 64'(NPIX));
    for (int i = 0; i < NPIX; i++)
      check_value($sformatf("pixel x=%0d y=%0d", i % LCD_W, i / LCD_W),
                  64'(pix[i]), 64'(expected_pixel(disp, i % LCD_W, i / LCD_W)));
  endtask

  // samples on rising spi_clk, one clock later so values are settled
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      dc_q   = 1'b1;
      sclk_q = 1'b0;
      dsh    = 16'h0;
      dbits  = 0;
      frames = 0;
    end
    else
    begin
      // dc falling opens a frame, display word is taken in this cycle
      if (dc_q && !spi_dc)
      begin
        frames++;
        frame_dt = datetime;
        cmd_q.delete();
        pix_q.delete();
        dbits = 0;
      end
      if (spi_clk && !sclk_q)
      begin
        dsh = {dsh[14:0], spi_mosi};
        dbits++;
        if (!spi_dc && dbits == 8)
        begin
          cmd_q.push_back(dsh[7:0]);
          dbits = 0;
        end
        else if (spi_dc && dbits == 16)
        begin
          pix_q.push_back(dsh);
          dbits = 0;
        end
      end
      dc_q   = spi_dc;
      sclk_q = spi_clk;
    end
  end

  initial
  begin
    void'($urandom(32'hdf76_5e0b));
    clk        = 1'b0;
    rst_n      = 1'b0;
    regs       = '0;
    force_nack = 1'b0;
    cur_regs   = '0;
    prev_dt    = '0;

    // reset held for two cycles
    @(posedge clk);
    cur_regs = random_regs();
    regs <= cur_regs;
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state();

    // first poll
    wait_tick(2 * POLL + 4000);
    check_value("datetime", 64'(datetime), 64'(packed_time(cur_regs)));

    // registers change, next poll picks them up
    @(posedge clk);
    cur_regs = random_regs();
    regs <= cur_regs;
    wait_tick(2 * POLL + 4000);
    check_value("datetime", 64'(datetime), 64'(packed_time(cur_regs)));

    // frame after the tick shows the new time
    wait_frame(40000);
    // panel reset released long before the first frame
    check_value("spi_resn", 64'(spi_resn), 64'(1'b1));
    check_value("frame datetime", 64'(frame_dt), 64'(packed_time(cur_regs)));
    wait_pixels(20000);
    check_frame();

    // slave refuses its address, nothing may change
    wait_tick(2 * POLL + 4000);
    prev_dt = datetime;
    @(posedge clk);
    cur_regs = random_regs();
    regs       <= cur_regs;
    force_nack <= 1'b1;
    for (int i = 0; i < 3 * POLL; i++)
    begin
      @(negedge clk);
      check_value("tick", 64'(tick), 64'(1'b0));
    end
    check_value("datetime", 64'(datetime), 64'(prev_dt));

    // acks back on, the current registers arrive
    @(posedge clk);
    force_nack <= 1'b0;
    wait_tick(2 * POLL + 4000);
    check_value("datetime", 64'(datetime), 64'(packed_time(cur_regs)));

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: src.f
verilog/rtc_pkg.sv
verilog/lcd_pkg.sv
verilog/rtc_reader.sv
verilog/hex_glyph.sv
verilog/lcd_stream.sv
verilog/rtc_lcd_top.sv
bench/rtc_i2c_model.sv
bench/tb_rtc_lcd.sv

// File: Makefile
# Verilator flow for the RTC clock display

TOP := tb_rtc_lcd

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
